/* all.f */
+incdir+include
logic/periph_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/pwm_ctrl.sv
logic/periph_bus.sv
logic/periph_top.sv
verification/periph_assertions.sv
verification/periph_tb.sv

/* Bender.yml */
package:
  name: periph_block

export_include_dirs:
  - include

sources:
  - logic/periph_pkg.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/pwm_ctrl.sv
  - logic/periph_bus.sv
  - logic/periph_top.sv
  - target: test
    files:
      - verification/periph_assertions.sv
      - verification/periph_tb.sv

/* verification/periph_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the peripheral block top level
//   Clock, reset and bus master tasks
//   Serial driver and transmit frame capture
//   Compare tasks and directed tests
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "periph_macros.svh"

module periph_tb;

    import periph_pkg::*;

    localparam int wait_limit = 200;
    localparam int bit_cycles = `UART_CLKS_PER_BIT;

    logic       clk;
    logic       rst_reg_n;
    bus_req_t   req;
    logic       req_valid;
    logic       req_ready;
    bus_rsp_t   rsp;
    logic       rsp_valid;
    logic [7:0] gpio_in;
    logic       uart_rxd;
    logic [7:0] pins_out;
    logic [3:0] irq;
    // Set by the last bus write that saw req_ready low
    logic       write_stalled;

    periph_top uut (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .gpio_in   (gpio_in),
        .uart_rxd  (uart_rxd),
        .pins_out  (pins_out),
        .irq       (irq)
    );

    bind periph_bus periph_assertions i_assertions (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .tx_busy   (tx_busy),
        .uart_txd  (uart_txd)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic fail_with(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    // Stop at the first protocol assertion failure
    always @(uut.i_bus.i_assertions.fail_count) begin
        if (uut.i_bus.i_assertions.fail_count != 0) begin
            fail_with("A bus protocol assertion failed");
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_irq(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    function automatic logic [27:0] reg_addr(input logic [3:0] idx);
        return {`PERIPH_BASE, idx, 2'b00};
    endfunction

    // Present a request and hold it until accepted
    task automatic present_req(input logic [27:0] addr, input logic write, input word_t data);
        int waited;
        waited = 0;
        @(posedge clk);
        req       <= {addr, write, data};
        req_valid <= 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            write_stalled = 1'b1;
            waited++;
            if (waited > wait_limit) begin
                fail_with("Bus request was never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic bus_write(input logic [27:0] addr, input word_t data);
        write_stalled = 1'b0;
        present_req(addr, 1'b1, data);
    endtask

    task automatic bus_read(input logic [27:0] addr, output word_t data);
        int waited;
        waited = 0;
        present_req(addr, 1'b0, 32'h0);
        @(negedge clk);
        while (!rsp_valid) begin
            waited++;
            if (waited > wait_limit) begin
                fail_with("Read response never arrived");
            end
            @(negedge clk);
        end
        data = rsp.rdata;
    endtask

    task automatic expect_read(input logic [27:0] addr, input word_t exp, input string name);
        word_t data;
        bus_read(addr, data);
        check_word(name, exp, data);
    endtask

    task automatic wait_irq_high(input int idx, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!irq[idx]) begin
            waited++;
            if (waited > wait_limit) begin
                fail_with(what);
            end
            @(negedge clk);
        end
    endtask

    // One 8N1 frame on uart_rxd, start bit first
    task automatic send_serial(input byte_t data);
        logic [9:0] frame;
        int i;
        frame = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rxd <= frame[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
    endtask

    // Samples pins_out bit 0 in the middle of each bit
    task automatic capture_frame(output logic [9:0] frame);
        int waited;
        int i;
        waited = 0;
        @(negedge clk);
        while (pins_out[0]) begin
            waited++;
            if (waited > wait_limit) begin
                fail_with("No start bit seen on the transmit pin");
            end
            @(negedge clk);
        end
        repeat (bit_cycles / 2) @(negedge clk);
        frame[0] = pins_out[0];
        for (i = 1; i < 10; i++) begin
            repeat (bit_cycles) @(negedge clk);
            frame[i] = pins_out[0];
        end
    endtask

    task automatic count_pwm_high(output int highs);
        highs = 0;
        repeat (256) begin
            @(negedge clk);
            if (pins_out[7]) begin
                highs++;
            end
        end
    endtask

    task automatic test_reset_state();
        int highs;
        @(negedge clk);
        check_byte("pins_out", 8'h01, pins_out);
        check_irq("irq", 4'b1000, irq);
        expect_read(reg_addr(`REG_GPIO_OUT_SEL), 32'h0, "rdata GPIO_OUT_SEL");
        expect_read(reg_addr(`REG_UART_STATUS), 32'h0, "rdata UART_STATUS");
        // Route PWM to bit 7 to see the reset level
        bus_write(reg_addr(`REG_GPIO_OUT_SEL), 32'h100);
        count_pwm_high(highs);
        check_word("pwm high cycles", 32'h0, word_t'(highs));
        bus_write(reg_addr(`REG_GPIO_OUT_SEL), 32'h0);
    endtask

    task automatic test_gpio();
        byte_t v;
        byte_t g;
        v = 8'($urandom);
        g = 8'($urandom);
        bus_write(reg_addr(`REG_GPIO_OUT_SEL), 32'h3FF);
        bus_write(reg_addr(`REG_GPIO_OUT), {24'h0, v});
        @(negedge clk);
        check_byte("pins_out", v, pins_out);
        expect_read(reg_addr(`REG_GPIO_OUT), {24'h0, v}, "rdata GPIO_OUT");
        @(posedge clk);
        gpio_in <= g;
        expect_read(reg_addr(`REG_GPIO_IN), {24'h0, g}, "rdata GPIO_IN");
        @(negedge clk);
        check_irq("irq", {2'b10, g[1:0]}, irq);
        // Inverted inputs toggle both low irq bits
        @(posedge clk);
        gpio_in <= ~g;
        repeat (2) @(negedge clk);
        check_irq("irq", {2'b10, ~g[1:0]}, irq);
        @(posedge clk);
        gpio_in <= 8'h00;
        // Alternate functions come back
        bus_write(reg_addr(`REG_GPIO_OUT_SEL), 32'h0);
        @(negedge clk);
        check_byte("pins_out", 8'h01, pins_out);
    endtask

    task automatic test_uart_tx();
        byte_t b1;
        byte_t b2;
        logic [9:0] f1;
        logic [9:0] f2;
        b1 = 8'($urandom);
        b2 = 8'($urandom);
        bus_write(reg_addr(`REG_UART), {24'h0, b1});
        fork
            begin
                capture_frame(f1);
                capture_frame(f2);
            end
            begin
                @(negedge clk);
                check_irq("irq", 4'b0000, irq);
                // Issued mid-frame, must wait for the stop bit
                bus_write(reg_addr(`REG_UART), {24'h0, b2});
            end
        join
        if (!write_stalled) begin
            fail_with("Second UART write was accepted while the transmitter was busy");
        end
        check_word("uart_txd frame 1", {22'h0, 1'b1, b1, 1'b0}, {22'h0, f1});
        check_word("uart_txd frame 2", {22'h0, 1'b1, b2, 1'b0}, {22'h0, f2});
        wait_irq_high(3, "Transmitter never went idle");
        check_irq("irq", 4'b1000, irq);
    endtask

    task automatic test_uart_rx();
        byte_t r;
        r = 8'($urandom);
        send_serial(r);
        wait_irq_high(2, "Receiver never flagged a byte");
        check_irq("irq", 4'b1100, irq);
        check_byte("pins_out", 8'h03, pins_out);
        expect_read(reg_addr(`REG_UART_STATUS), 32'h2, "rdata UART_STATUS full");
        expect_read(reg_addr(`REG_UART), {24'h0, r}, "rdata UART");
        expect_read(reg_addr(`REG_UART_STATUS), 32'h0, "rdata UART_STATUS popped");
    endtask

    task automatic test_pwm();
        byte_t lvl;
        int highs;
        lvl = 8'($urandom % 255 + 1);
        bus_write(reg_addr(`REG_GPIO_OUT_SEL), 32'h100);
        bus_write(reg_addr(`REG_PWM), {24'h0, lvl});
        count_pwm_high(highs);
        check_word("pwm high cycles", {24'h0, lvl}, word_t'(highs));
        bus_write(reg_addr(`REG_PWM), 32'h0);
        bus_write(reg_addr(`REG_GPIO_OUT_SEL), 32'h0);
    endtask

    task automatic test_addressing();
        byte_t v;
        logic [27:0] outside;
        v = 8'($urandom);
        outside = {`PERIPH_BASE ^ 22'h00_0001, `REG_GPIO_OUT, 2'b00};
        bus_write(reg_addr(`REG_GPIO_OUT_SEL), 32'h0FF);
        bus_write(reg_addr(`REG_GPIO_OUT), {24'h0, v});
        expect_read(outside, 32'hFFFF_FFFF, "rdata outside window");
        expect_read(reg_addr(4'h2), 32'hFFFF_FFFF, "rdata unmapped index");
        bus_write(outside, {24'h0, ~v});
        bus_write(reg_addr(4'h2), {24'h0, ~v});
        bus_write(reg_addr(`REG_GPIO_IN), {24'h0, ~v});
        bus_write({`PERIPH_BASE, `REG_GPIO_OUT, 2'b01}, {24'h0, ~v});
        expect_read(reg_addr(`REG_GPIO_OUT), {24'h0, v}, "rdata GPIO_OUT kept");
        bus_write(reg_addr(`REG_GPIO_OUT_SEL), 32'h0);
    endtask

    initial begin
        void'($urandom(32'haf941ea9));
        clk           = 1'b0;
        rst_reg_n     = 1'b0;
        req           = '0;
        req_valid     = 1'b0;
        gpio_in       = 8'h00;
        uart_rxd      = 1'b1;
        write_stalled = 1'b0;
        repeat (5) @(posedge clk);
        rst_reg_n <= 1'b1;
        test_reset_state();
        test_gpio();
        test_uart_tx();
        test_uart_rx();
        test_pwm();
        test_addressing();
        @(negedge clk);
        if (uut.i_bus.i_assertions.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_with("A bus protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

/* verification/periph_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// Bus protocol assertions for the peripheral bus block
//   Request held while stalled
//   One read response per accepted read
//   Idle transmit line and back-pressure source
//   Count of failed assertions
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "periph_macros.svh"

module periph_assertions (
    input  wire                       clk,
    input  wire                       rst_reg_n,
    input  wire periph_pkg::bus_req_t req,
    input  wire                       req_valid,
    input  wire                       req_ready,
    input  wire                       rsp_valid,
    input  wire                       tx_busy,
    input  wire                       uart_txd
);

    logic uart_write;
    logic read_accept;
    int   fail_count = 0;

    // Write aimed at the UART data register
    assign uart_write = req_valid && req.write && (req.addr[27:6] == `PERIPH_BASE)
                        && (req.addr[5:2] == `REG_UART) && (req.addr[1:0] == 2'b00);
    assign read_accept = req_valid && req_ready && !req.write;

    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_reg_n)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else begin
            $error("Request changed while it was stalled");
            fail_count++;
        end

    a_rsp_after_read: assert property (@(posedge clk) disable iff (!rst_reg_n)
        rsp_valid |-> $past(read_accept))
        else begin
            $error("Response without an accepted read");
            fail_count++;
        end

    a_read_gets_rsp: assert property (@(posedge clk) disable iff (!rst_reg_n)
        read_accept |=> rsp_valid)
        else begin
            $error("Accepted read got no response");
            fail_count++;
        end

    a_txd_idle: assert property (@(posedge clk) disable iff (!rst_reg_n)
        !tx_busy |-> uart_txd)
        else begin
            $error("Transmit line low while the transmitter is idle");
            fail_count++;
        end

    a_ready_source: assert property (@(posedge clk) disable iff (!rst_reg_n)
        !req_ready |-> (uart_write && tx_busy))
        else begin
            $error("Request stalled outside a busy UART write");
            fail_count++;
        end

endmodule

`default_nettype wire

/* logic/periph_top.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral block top level
//   Bus block, UART transmitter and receiver, PWM generator
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "periph_macros.svh"

module periph_top (
    input  wire                     clk,
    input  wire                     rst_reg_n,
    input  wire periph_pkg::bus_req_t req,
    input  wire                     req_valid,
    output logic                    req_ready,
    output periph_pkg::bus_rsp_t    rsp,
    output logic                    rsp_valid,
    input  wire [7:0]               gpio_in,
    input  wire                     uart_rxd,
    output logic [7:0]              pins_out,
    output logic [3:0]              irq
);

    import periph_pkg::*;

    logic  tx_start;
    byte_t tx_data;
    logic  tx_busy;
    logic  uart_txd;
    logic  rx_pop;
    logic  rx_valid;
    byte_t rx_data;
    logic  uart_rts;
    logic  pwm_load;
    byte_t pwm_level;
    logic  pwm_out;

    periph_bus i_bus (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .rx_pop    (rx_pop),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .uart_txd  (uart_txd),
        .uart_rts  (uart_rts),
        .pwm_load  (pwm_load),
        .pwm_level (pwm_level),
        .pwm_out   (pwm_out),
        .gpio_in   (gpio_in),
        .pins_out  (pins_out),
        .irq       (irq)
    );

    uart_tx #(.clks_per_bit(`UART_CLKS_PER_BIT)) i_uart_tx (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .uart_txd  (uart_txd),
        .tx_busy   (tx_busy)
    );

    uart_rx #(.clks_per_bit(`UART_CLKS_PER_BIT)) i_uart_rx (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .uart_rxd  (uart_rxd),
        .rx_pop    (rx_pop),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .uart_rts  (uart_rts)
    );

    pwm_ctrl i_pwm (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .pwm_load  (pwm_load),
        .pwm_level (pwm_level),
        .pwm_out   (pwm_out)
    );

endmodule

`default_nettype wire

/* logic/periph_bus.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral bus block
//   Window decode and valid/ready handshake with UART back-pressure
//   GPIO output and output-select registers
//   Registered read multiplexer
//   Pin multiplexer and interrupt vector
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "periph_macros.svh"

module periph_bus (
    input  wire                     clk,
    input  wire                     rst_reg_n,
    input  wire periph_pkg::bus_req_t req,
    input  wire                     req_valid,
    output logic                    req_ready,
    output periph_pkg::bus_rsp_t    rsp,
    output logic                    rsp_valid,
    output logic                    tx_start,
    output periph_pkg::byte_t       tx_data,
    input  wire                     tx_busy,
    output logic                    rx_pop,
    input  wire                     rx_valid,
    input  wire periph_pkg::byte_t  rx_data,
    input  wire                     uart_txd,
    input  wire                     uart_rts,
    output logic                    pwm_load,
    output periph_pkg::byte_t       pwm_level,
    input  wire                     pwm_out,
    input  wire [7:0]               gpio_in,
    output logic [7:0]              pins_out,
    output logic [3:0]              irq
);

    import periph_pkg::*;

    logic         in_window;
    periph_reg_e  reg_idx;
    logic         accept;
    logic         wr_en;
    logic         rd_en;
    logic [7:0]   gpio_out;
    logic [9:0]   gpio_out_sel;
    logic [7:0]   alt_func;
    logic [1:0]   gpio_in_q;
    uart_status_t uart_status;
    word_t        rdata_next;

    // Word-aligned addresses inside the window only
    assign in_window = (req.addr[27:6] == `PERIPH_BASE) && (req.addr[1:0] == 2'b00);
    assign reg_idx   = in_window ? periph_reg_e'(req.addr[5:2]) : reg_none;

    // Stall a UART write until the transmitter is free
    assign req_ready = !(req_valid && req.write && reg_idx == reg_uart && tx_busy);
    assign accept    = req_valid && req_ready;
    assign wr_en     = accept && req.write;
    assign rd_en     = accept && !req.write;

    assign tx_start  = wr_en && reg_idx == reg_uart;
    assign tx_data   = req.wdata[7:0];
    assign rx_pop    = rd_en && reg_idx == reg_uart;
    assign pwm_load  = wr_en && reg_idx == reg_pwm;
    assign pwm_level = req.wdata[7:0];

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            gpio_out     <= '0;
            gpio_out_sel <= '0;
        end else if (wr_en) begin
            if (reg_idx == reg_gpio_out) begin
                gpio_out <= req.wdata[7:0];
            end
            if (reg_idx == reg_gpio_out_sel) begin
                gpio_out_sel <= req.wdata[9:0];
            end
        end
    end

    // Alternate functions, PWM on bit 7 needs select bit 8
    assign alt_func = {pwm_out & gpio_out_sel[8], 5'b00000, uart_rts, uart_txd};
    assign pins_out = (gpio_out & gpio_out_sel[7:0]) | (alt_func & ~gpio_out_sel[7:0]);

    always_ff @(posedge clk) begin
        gpio_in_q <= gpio_in[1:0];
    end

    assign irq = {!tx_busy, rx_valid, gpio_in_q};

    assign uart_status.rx_valid = rx_valid;
    assign uart_status.tx_busy  = tx_busy;

    always_comb begin
        case (reg_idx)
            reg_gpio_out:     rdata_next = {24'h0, pins_out};
            reg_gpio_in:      rdata_next = {24'h0, gpio_in};
            reg_gpio_out_sel: rdata_next = {22'h0, gpio_out_sel};
            reg_uart:         rdata_next = {24'h0, rx_data};
            reg_uart_status:  rdata_next = {30'h0, uart_status};
            default:          rdata_next = '1;
        endcase
    end

    // Response one cycle after an accepted read
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rsp.rdata <= rdata_next;
        end
    end

endmodule

`default_nettype wire

/* logic/pwm_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// PWM generator
//   Free-running 8-bit counter
//   Loadable level, output high while the counter is below it
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module pwm_ctrl (
    input  wire                clk,
    input  wire                rst_reg_n,
    input  wire                pwm_load,
    input  wire periph_pkg::byte_t pwm_level,
    output logic               pwm_out
);

    import periph_pkg::*;

    byte_t pwm_cnt;
    byte_t level_q;

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            pwm_cnt <= '0;
            level_q <= '0;
        end else begin
            // Wraps every 256 cycles
            pwm_cnt <= pwm_cnt + 8'd1;
            if (pwm_load) begin
                level_q <= pwm_level;
            end
        end
    end

    // Level of zero gives a constant low output
    assign pwm_out = pwm_cnt < level_q;

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
////////////////////////////////////////////////////////////////////////////
// UART receiver
//   Two-flop input synchronizer and start edge detect
//   Mid-bit sampling with stop bit check
//   One-byte holding register, RTS while it is full
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module uart_rx #(
    parameter int clks_per_bit = 8
) (
    input  wire                clk,
    input  wire                rst_reg_n,
    input  wire                uart_rxd,
    input  wire                rx_pop,
    output logic               rx_valid,
    output periph_pkg::byte_t  rx_data,
    output logic               uart_rts
);

    import periph_pkg::*;

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    logic [1:0]       state;
    logic [cnt_w-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    byte_t            rx_shift;

    // Synchronizer, held at the idle level in reset
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            state    <= st_idle;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_pop) begin
                rx_valid <= 1'b0;
            end
            case (state)
                st_idle: begin
                    // Falling edge marks the start bit
                    if (rxd_prev && !rxd_sync) begin
                        state   <= st_start;
                        bit_cnt <= '0;
                    end
                end
                st_start: begin
                    if (bit_cnt == half_last) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // A glitch that is high again at mid-bit is ignored
                        state   <= rxd_sync ? st_idle : st_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_cnt == bit_last) begin
                        bit_cnt  <= '0;
                        rx_shift <= {rxd_sync, rx_shift[7:1]};
                        bit_idx  <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_cnt == bit_last) begin
                        bit_cnt <= '0;
                        state   <= st_idle;
                        // Byte is dropped while the holding register is full
                        if (rxd_sync && !rx_valid) begin
                            rx_data  <= rx_shift;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign uart_rts = rx_valid;

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
////////////////////////////////////////////////////////////////////////////
// UART transmitter
//   8N1 frames, LSB first
//   Busy from the cycle after start to the end of the stop bit
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 8
) (
    input  wire                 clk,
    input  wire                 rst_reg_n,
    input  wire                 tx_start,
    input  wire periph_pkg::byte_t tx_data,
    output logic                uart_txd,
    output logic                tx_busy
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

    // Cycle within the current bit
    logic [cnt_w-1:0] bit_cnt;
    // Bit of the frame being sent, 0 is the start bit
    logic [3:0]       bit_idx;
    logic [9:0]       tx_shift;

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            tx_busy <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy  <= 1'b1;
                bit_cnt  <= '0;
                bit_idx  <= '0;
                // Stop bit, data, start bit
                tx_shift <= {1'b1, tx_data, 1'b0};
            end
        end else if (bit_cnt == bit_last) begin
            bit_cnt  <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Line idles high between frames
    assign uart_txd = tx_busy ? tx_shift[0] : 1'b1;

endmodule

`default_nettype wire

/* logic/periph_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral block types
//   Data word and byte types
//   Bus request and response structs
//   Register index enum
//   UART status layout
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "periph_macros.svh"

package periph_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Word request from the bus master
    typedef struct packed {
        logic [27:0] addr;
        logic        write;
        word_t       wdata;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
    } bus_rsp_t;

    // Decoded register, reg_none for anything outside the window
    typedef enum logic [3:0] {
        reg_gpio_out     = `REG_GPIO_OUT,
        reg_gpio_in      = `REG_GPIO_IN,
        reg_gpio_out_sel = `REG_GPIO_OUT_SEL,
        reg_uart         = `REG_UART,
        reg_uart_status  = `REG_UART_STATUS,
        reg_pwm          = `REG_PWM,
        reg_none         = 4'hF
    } periph_reg_e;

    // Low bits of the UART status register
    typedef struct packed {
        logic rx_valid;
        logic tx_busy;
    } uart_status_t;

endpackage

`default_nettype wire

/* include/periph_macros.svh */
////////////////////////////////////////////////////////////////////////////
// Peripheral block constants
//   Base address of the peripheral window
//   Register indices taken from address bits 5:2
//   UART bit timing
////////////////////////////////////////////////////////////////////////////

`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// Value of address bits 27:6 that selects the window
`define PERIPH_BASE 22'h20_0000

// Register indices
`define REG_GPIO_OUT     4'h0
`define REG_GPIO_IN      4'h1
`define REG_GPIO_OUT_SEL 4'h3
`define REG_UART         4'h4
`define REG_UART_STATUS  4'h5
`define REG_PWM          4'hA

// Clocks per serial bit, kept short for simulation
`define UART_CLKS_PER_BIT 8

`endif
